// File: tilemap_pkg.sv
`default_nettype none

package tilemap_pkg;

    localparam int line_pixels     = 448;   // visible pixels per line
    localparam int tile_fifo_depth = 2;     // also the sender's credits after reset
    localparam int ptr_w           = $clog2(tile_fifo_depth);
    localparam int cnt_w           = $clog2(tile_fifo_depth + 1);

    // rom region, placed in rom_addr[22:20]
    localparam logic [2:0] rom_id_8  = 3'd1;
    localparam logic [2:0] rom_id_16 = 3'd2;
    localparam logic [2:0] rom_id_32 = 3'd3;

    // tile_scan states
    localparam logic [2:0] scan_idle  = 3'd0;
    localparam logic [2:0] scan_addr  = 3'd1;   // put the code address on vram
    localparam logic [2:0] scan_code  = 3'd2;
    localparam logic [2:0] scan_attr  = 3'd3;
    localparam logic [2:0] scan_send  = 3'd4;   // waiting for a credit
    localparam logic [2:0] scan_drain = 3'd5;   // waiting for all credits to come back

    // rom offset inside a region, the layout depends on the tile size
    typedef union packed {
        struct packed {
            logic        zero;
            logic [15:0] code;
            logic [2:0]  row;
        } t8;
        struct packed {
            logic [15:0] code;
            logic [3:0]  row;
        } t16;
        struct packed {
            logic [13:0] code;
            logic [4:0]  row;
            logic        col;   // left or right 16 pixels of the tile
        } t32;
    } rom_addr_u;

endpackage

`default_nettype wire

// File: stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// one tile per valid, scan to rom fetch
interface tile_if;
    logic        valid;
    logic [15:0] code;
    logic [4:0]  pal;
    logic        hflip;
    logic        vflip;
    logic [4:0]  row;     // line inside the tile, vflip not applied yet
    logic        last;    // final tile of the line
    logic        credit;  // pulses once per FIFO pop

    modport src (
        output valid, code, pal, hflip, vflip, row, last,
        input  credit
    );
    modport dst (
        input  valid, code, pal, hflip, vflip, row, last,
        output credit
    );
endinterface

// one planar word (8 pixels) per valid, rom fetch to pixel output
interface pix_if;
    logic        valid;
    logic [31:0] data;
    logic [4:0]  pal;
    logic        hflip;
    logic        last;    // final word of the line
    logic        credit;

    modport src (output valid, data, pal, hflip, last, input credit);
    modport dst (input valid, data, pal, hflip, last, output credit);
endinterface

`default_nettype wire

// File: tile_scan.sv
`timescale 1ns/10ps
`default_nettype none

module tile_scan (
    input  logic        clk,
    input  logic        rst,
    input  logic [8:0]  vrender,
    input  logic [2:0]  size,       // one-hot, bit 0 = 8x8, bit 1 = 16x16, bit 2 = 32x32
    input  logic [15:0] vram_base,
    input  logic [15:0] hpos,
    input  logic [15:0] vpos,
    input  logic        start,
    output logic [17:1] vram_addr,
    output logic        vram_cs,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    tile_if.src         tile,
    output logic        busy
);

    logic [2:0]  st;
    logic [10:0] vn;
    logic [10:0] hn;           // left column of the current tile
    logic [5:0]  tiles_left;
    logic [tilemap_pkg::cnt_w-1:0] credits;
    logic [11:0] idx;
    logic [4:0]  fine;
    logic [5:0]  ntiles;
    logic        send;

    // map index, same packing as the original chip
    always_comb begin
        case (size)
            3'b001:  idx = {vn[8], hn[8:3], vn[7:3]};
            3'b010:  idx = {vn[9:8], hn[9:4], vn[7:4]};
            default: idx = {vn[10:8], hn[10:5], vn[7:5]};
        endcase
    end

    always_comb begin
        if (size[0]) begin
            fine   = {2'd0, hpos[2:0]};
            ntiles = 6'(tilemap_pkg::line_pixels / 8);
        end else if (size[1]) begin
            fine   = {1'b0, hpos[3:0]};
            ntiles = 6'(tilemap_pkg::line_pixels / 16);
        end else begin
            fine   = hpos[4:0];
            ntiles = 6'(tilemap_pkg::line_pixels / 32);
        end
        ntiles = ntiles + {5'd0, fine != 5'd0};   // a partial tile on the left
    end

    assign send = ((st == tilemap_pkg::scan_attr && vram_ok) || st == tilemap_pkg::scan_send)
                  && credits != '0;
    assign busy = st != tilemap_pkg::scan_idle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= tilemap_pkg::scan_idle;
            vram_cs    <= 1'b0;
            tile.valid <= 1'b0;
            credits    <= (tilemap_pkg::cnt_w)'(tilemap_pkg::tile_fifo_depth);
        end else begin
            tile.valid <= send;
            credits    <= credits + (tilemap_pkg::cnt_w)'(tile.credit)
                          - (tilemap_pkg::cnt_w)'(send);
            case (st)
                tilemap_pkg::scan_idle: if (start) st <= tilemap_pkg::scan_addr;
                tilemap_pkg::scan_addr: begin
                    vram_cs <= 1'b1;
                    st      <= tilemap_pkg::scan_code;
                end
                tilemap_pkg::scan_code: if (vram_ok) st <= tilemap_pkg::scan_attr;
                tilemap_pkg::scan_attr: if (vram_ok) begin
                    vram_cs <= 1'b0;
                    if (!send)
                        st <= tilemap_pkg::scan_send;
                    else
                        st <= tiles_left == 6'd1 ? tilemap_pkg::scan_drain
                                                 : tilemap_pkg::scan_addr;
                end
                tilemap_pkg::scan_send: if (send)
                    st <= tiles_left == 6'd1 ? tilemap_pkg::scan_drain : tilemap_pkg::scan_addr;
                tilemap_pkg::scan_drain:
                    if (credits == (tilemap_pkg::cnt_w)'(tilemap_pkg::tile_fifo_depth))
                        st <= tilemap_pkg::scan_idle;
                default: st <= tilemap_pkg::scan_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == tilemap_pkg::scan_idle && start) begin
            vn         <= vpos[10:0] + {2'd0, vrender};
            hn         <= hpos[10:0] - {6'd0, fine};   // clear the fine bits
            tiles_left <= ntiles;
        end
        if (st == tilemap_pkg::scan_addr)
            vram_addr <= {vram_base[9:1], 8'd0} + {4'd0, idx, 1'b0};
        if (st == tilemap_pkg::scan_code && vram_ok) begin
            tile.code    <= vram_data;
            vram_addr[1] <= 1'b1;   // attribute is the next word
        end
        if (st == tilemap_pkg::scan_attr && vram_ok) begin
            tile.vflip <= vram_data[6];
            tile.hflip <= vram_data[5];
            tile.pal   <= vram_data[4:0];
            tile.row   <= vn[4:0];
            tile.last  <= tiles_left == 6'd1;
            hn         <= hn + (size[0] ? 11'd8 : (size[1] ? 11'd16 : 11'd32));
        end
        if (send)
            tiles_left <= tiles_left - 6'd1;
    end

    a_size_onehot: assert property (@(posedge clk) disable iff (rst)
        start && st == tilemap_pkg::scan_idle |-> $onehot(size))
        else $error("line started with a tile size that is not one-hot");

endmodule

`default_nettype wire

// File: tile_rom_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module tile_rom_fetch (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  size,
    tile_if.dst         tile,
    pix_if.src          pix,
    output logic [22:0] rom_addr,
    output logic        rom_half,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok
);

    logic [28:0] fifo [tilemap_pkg::tile_fifo_depth];
    logic [tilemap_pkg::ptr_w-1:0] wp, rp;
    logic [tilemap_pkg::cnt_w-1:0] used, credits;
    logic        active;       // a tile is being read out
    logic [1:0]  word;         // read number inside the tile
    logic        hf, tlast;
    logic [4:0]  pal;
    logic        pop, got, final_word;
    logic [15:0] h_code;
    logic [4:0]  h_pal, h_row;
    logic        h_hf, h_vf, h_last;
    logic [2:0]  rid;
    tilemap_pkg::rom_addr_u off, off_nxt;

    assign {h_code, h_pal, h_hf, h_vf, h_row, h_last} = fifo[rp];

    // a tile is only started with a word slot free downstream
    assign pop = !active && used != '0 && credits != '0;
    assign got = rom_cs && rom_ok;
    assign final_word = size[0] ? word == 2'd0 : (size[1] ? word == 2'd1 : word == 2'd3);
    assign rom_addr = {rid, off};

    always_comb begin
        off_nxt = '0;
        case (size)
            3'b001: begin
                rid              = tilemap_pkg::rom_id_8;
                off_nxt.t8.code  = h_code;
                off_nxt.t8.row   = h_row[2:0] ^ {3{h_vf}};
            end
            3'b010: begin
                rid              = tilemap_pkg::rom_id_16;
                off_nxt.t16.code = h_code;
                off_nxt.t16.row  = h_row[3:0] ^ {4{h_vf}};
            end
            default: begin
                rid              = tilemap_pkg::rom_id_32;
                off_nxt.t32.code = h_code[13:0];
                off_nxt.t32.row  = h_row ^ {5{h_vf}};
                off_nxt.t32.col  = h_hf;   // mirrored tiles start on the right half
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wp          <= '0;
            rp          <= '0;
            used        <= '0;
            credits     <= (tilemap_pkg::cnt_w)'(tilemap_pkg::tile_fifo_depth);
            active      <= 1'b0;
            rom_cs      <= 1'b0;
            pix.valid   <= 1'b0;
            tile.credit <= 1'b0;
        end else begin
            tile.credit <= pop;
            pix.valid   <= got;
            used        <= used + (tilemap_pkg::cnt_w)'(tile.valid)
                           - (tilemap_pkg::cnt_w)'(pop);
            credits     <= credits + (tilemap_pkg::cnt_w)'(pix.credit)
                           - (tilemap_pkg::cnt_w)'(got);
            if (tile.valid)
                wp <= wp + 1'b1;
            if (pop) begin
                rp     <= rp + 1'b1;
                active <= 1'b1;
                rom_cs <= 1'b1;
            end else if (got) begin
                rom_cs <= 1'b0;
                if (final_word)
                    active <= 1'b0;
            end else if (active && !rom_cs && credits != '0) begin
                rom_cs <= 1'b1;   // next word of the same tile
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile.valid)
            fifo[wp] <= {tile.code, tile.pal, tile.hflip, tile.vflip, tile.row, tile.last};
        if (pop) begin
            off      <= off_nxt;
            rom_half <= h_hf;
            word     <= 2'd0;
            hf       <= h_hf;
            pal      <= h_pal;
            tlast    <= h_last;
        end else if (got) begin
            rom_half <= ~rom_half;
            word     <= word + 2'd1;
            if (size[2] && word[0])
                off.t32.col <= ~off.t32.col;   // every second read
        end
        if (got) begin
            pix.data  <= rom_data;
            pix.pal   <= pal;
            pix.hflip <= hf;
            pix.last  <= tlast && final_word;
        end
    end

    // the slot downstream stays reserved for the whole request
    a_cs_credit: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> credits != '0)
        else $error("rom read outstanding without a pixel credit");

    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr) && $stable(rom_half))
        else $error("rom request changed before rom_ok");

endmodule

`default_nettype wire

// File: tile_pixel_out.sv
`timescale 1ns/10ps
`default_nettype none

module tile_pixel_out (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [15:0] hpos,
    input  logic [2:0]  size,
    pix_if.dst          pix,
    output logic [8:0]  buf_addr,
    output logic [8:0]  buf_data,
    output logic        buf_wr,
    output logic        done
);

    logic [38:0] fifo [tilemap_pkg::tile_fifo_depth];
    logic [tilemap_pkg::ptr_w-1:0] wp, rp;
    logic [tilemap_pkg::cnt_w-1:0] used;
    logic [31:0] sh;           // word being shifted out
    logic [4:0]  pal;
    logic        hf, cur_last;
    logic [3:0]  px_left;
    logic [8:0]  wa;
    logic        wr_on, past_end;
    logic        pop, emit;
    logic [4:0]  fine;
    logic [31:0] h_data;
    logic [4:0]  h_pal;
    logic        h_hf, h_last;
    logic [3:0]  colour;

    assign {h_data, h_pal, h_hf, h_last} = fifo[rp];
    assign emit   = px_left != 4'd0;
    assign pop    = used != '0 && px_left <= 4'd1;   // next word follows without a gap
    assign colour = hf ? {sh[24], sh[16], sh[8], sh[0]} : {sh[31], sh[23], sh[15], sh[7]};
    assign fine   = size[0] ? {2'd0, hpos[2:0]} : (size[1] ? {1'b0, hpos[3:0]} : hpos[4:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wp         <= '0;
            rp         <= '0;
            used       <= '0;
            px_left    <= 4'd0;
            wr_on      <= 1'b0;
            past_end   <= 1'b0;
            buf_wr     <= 1'b0;
            done       <= 1'b0;
            pix.credit <= 1'b0;
        end else begin
            pix.credit <= pop;
            used       <= used + (tilemap_pkg::cnt_w)'(pix.valid)
                          - (tilemap_pkg::cnt_w)'(pop);
            if (pix.valid)
                wp <= wp + 1'b1;
            if (pop) begin
                rp      <= rp + 1'b1;
                px_left <= 4'd8;
            end else if (emit) begin
                px_left <= px_left - 4'd1;
            end
            buf_wr <= emit && wr_on;
            done   <= emit && px_left == 4'd1 && cur_last;
            if (start)
                wr_on <= 1'b1;
            else if (emit && wa == 9'(tilemap_pkg::line_pixels - 1))
                wr_on <= 1'b0;   // rest of the line is dropped
            if (start)
                past_end <= 1'b0;
            else if (buf_wr && buf_addr == 9'(tilemap_pkg::line_pixels - 1))
                past_end <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pix.valid)
            fifo[wp] <= {pix.data, pix.pal, pix.hflip, pix.last};
        if (start)
            wa <= 9'd0 - {4'd0, fine};   // partial tile lands off screen
        else if (emit)
            wa <= wa + 9'd1;
        if (pop) begin
            sh       <= h_data;
            pal      <= h_pal;
            hf       <= h_hf;
            cur_last <= h_last;
        end else if (emit) begin
            sh <= hf ? sh >> 1 : sh << 1;
        end
        buf_addr <= wa;
        buf_data <= {pal, colour};
    end

    a_no_late_write: assert property (@(posedge clk) disable iff (rst)
        past_end |-> !buf_wr)
        else $error("line buffer written after the last visible pixel");

endmodule

`default_nettype wire

// File: tilemap_render.sv
`timescale 1ns/10ps
`default_nettype none

module tilemap_render (
    input  logic        rst,
    input  logic        clk,
    input  logic [8:0]  vrender,    // line being rendered
    input  logic [2:0]  size,       // one-hot tile size
    input  logic [15:0] vram_base,
    input  logic [15:0] hpos,
    input  logic [15:0] vpos,
    input  logic        start,
    output logic        done,
    output logic [17:1] vram_addr,
    output logic        vram_cs,
    input  logic [15:0] vram_data,
    input  logic        vram_ok,
    output logic [22:0] rom_addr,
    output logic        rom_half,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic [8:0]  buf_addr,
    output logic [8:0]  buf_data,
    output logic        buf_wr
);

    logic busy;
    logic start_ok;

    tile_if tile_ch ();
    pix_if  pix_ch ();

    assign start_ok = start && !busy;   // a start during a line is ignored

    tile_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .vrender   (vrender),
        .size      (size),
        .vram_base (vram_base),
        .hpos      (hpos),
        .vpos      (vpos),
        .start     (start_ok),
        .vram_addr (vram_addr),
        .vram_cs   (vram_cs),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .tile      (tile_ch),
        .busy      (busy)
    );

    tile_rom_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .size     (size),
        .tile     (tile_ch),
        .pix      (pix_ch),
        .rom_addr (rom_addr),
        .rom_half (rom_half),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    tile_pixel_out u_pixel (
        .clk      (clk),
        .rst      (rst),
        .start    (start_ok),
        .hpos     (hpos),
        .size     (size),
        .pix      (pix_ch),
        .buf_addr (buf_addr),
        .buf_data (buf_data),
        .buf_wr   (buf_wr),
        .done     (done)
    );

endmodule

`default_nettype wire

// File: tb_tilemap.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tilemap;

    logic        clk = 1'b0;
    logic        rst;
    logic [8:0]  vrender;
    logic [2:0]  size;
    logic [15:0] vram_base, hpos, vpos;
    logic        start;
    logic        done;
    logic [17:1] vram_addr;
    logic        vram_cs;
    logic [15:0] vram_data = '0;
    logic        vram_ok = 1'b0;
    logic [22:0] rom_addr;
    logic        rom_half, rom_cs;
    logic [31:0] rom_data = '0;
    logic        rom_ok = 1'b0;
    logic [8:0]  buf_addr, buf_data;
    logic        buf_wr;

    logic [15:0] vram_mem [logic [16:0]];
    logic [31:0] rom_mem [logic [23:0]];   // key is {rom_addr, rom_half}
    int          lat_mode = 0;   // 0 random 1..6, 1 always 0, 2 always 8, 3 mix of 0 and 8
    int          vram_wait = 0;
    int          rom_wait = 0;
    int          region_bad = 0;
    logic        cap_clear;
    logic [9:0]  got_line [512];   // bit 9 marks a written entry
    logic [9:0]  exp_line [512];
    int          got_count = 0;
    int          done_count = 0;
    int          errors = 0;
    int          lines = 0;
    bit          hung = 1'b0;

    always #20 clk = ~clk;

    tilemap_render DUT (.*);

    // random contents are created on first use by the reference
    function automatic logic [15:0] vram_entry(input logic [16:0] a);
        if (!vram_mem.exists(a))
            vram_mem[a] = 16'($urandom);
        return vram_mem[a];
    endfunction

    function automatic logic [31:0] rom_entry(input logic [23:0] k);
        if (!rom_mem.exists(k))
            rom_mem[k] = $urandom;
        return rom_mem[k];
    endfunction

    function automatic int next_latency();
        case (lat_mode)
            1:       return 0;
            2:       return 8;
            3:       return ($urandom % 2) != 0 ? 8 : 0;
            default: return 1 + int'($urandom % 6);
        endcase
    endfunction

    function automatic logic [2:0] expected_region(input logic [2:0] sz);
        if (sz[0])
            return tilemap_pkg::rom_id_8;
        else if (sz[1])
            return tilemap_pkg::rom_id_16;
        return tilemap_pkg::rom_id_32;
    endfunction

    // expected line image in exp_line, returns the number of writes
    function automatic int expect_line(input logic [2:0] sz, input logic [8:0] vr,
            input logic [15:0] base, input logic [15:0] hp, input logic [15:0] vp);
        int          w, fine, ntiles, addr, count;
        logic [10:0] vn, hn;
        logic [11:0] idx;
        logic [16:0] caddr;
        logic [15:0] code, attr;
        logic [4:0]  row;
        logic [31:0] word;
        logic [3:0]  colour;
        logic        half;
        bit          writing;
        tilemap_pkg::rom_addr_u off;
        w      = sz[0] ? 8 : (sz[1] ? 16 : 32);
        fine   = int'(hp[4:0]) & (w - 1);
        vn     = vp[10:0] + {2'd0, vr};
        hn     = hp[10:0] - 11'(fine);
        ntiles = (tilemap_pkg::line_pixels + fine + w - 1) / w;
        addr   = (512 - fine) % 512;
        count  = 0;
        writing = 1'b1;
        for (int i = 0; i < 512; i++)
            exp_line[i] = '0;
        for (int t = 0; t < ntiles; t++) begin
            case (w)
                8:       idx = {vn[8], hn[8:3], vn[7:3]};
                16:      idx = {vn[9:8], hn[9:4], vn[7:4]};
                default: idx = {vn[10:8], hn[10:5], vn[7:5]};
            endcase
            caddr = {base[9:1], 8'd0} + {4'd0, idx, 1'b0};
            code  = vram_entry(caddr);
            attr  = vram_entry(caddr + 17'd1);
            row   = vn[4:0] & 5'(w - 1);
            if (attr[6])
                row = row ^ 5'(w - 1);   // vflip
            for (int k = 0; k < w / 8; k++) begin
                off = '0;
                case (w)
                    8: begin
                        off.t8.code = code;
                        off.t8.row  = row[2:0];
                    end
                    16: begin
                        off.t16.code = code;
                        off.t16.row  = row[3:0];
                    end
                    default: begin
                        off.t32.code = code[13:0];
                        off.t32.row  = row;
                        off.t32.col  = attr[5] ^ (k >= 2);
                    end
                endcase
                half = attr[5] ^ (k % 2 == 1);
                word = rom_entry({expected_region(sz), off, half});
                for (int p = 0; p < 8; p++) begin
                    if (attr[5]) begin
                        colour = {word[24], word[16], word[8], word[0]};
                        word   = word >> 1;
                    end else begin
                        colour = {word[31], word[23], word[15], word[7]};
                        word   = word << 1;
                    end
                    if (writing) begin
                        exp_line[addr] = {1'b1, attr[4:0], colour};
                        count++;
                        if (addr == tilemap_pkg::line_pixels - 1)
                            writing = 1'b0;
                    end
                    addr = (addr + 1) % 512;
                end
            end
            hn = hn + 11'(w);
        end
        return count;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // vram model, answers after a random wait with the address held
    always @(posedge clk) begin
        vram_ok <= 1'b0;
        if (vram_ok) begin
            vram_wait <= next_latency();
        end else if (vram_cs) begin
            if (vram_wait == 0) begin
                vram_ok   <= 1'b1;
                vram_data <= vram_mem.exists(vram_addr) ? vram_mem[vram_addr]
                             : 16'(vram_addr) ^ 16'(vram_addr >> 16) ^ 16'h5a5a;
            end else begin
                vram_wait <= vram_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (cap_clear)
            region_bad <= 0;
        if (rom_ok) begin
            rom_wait <= next_latency();
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_mem.exists({rom_addr, rom_half}) ? rom_mem[{rom_addr, rom_half}]
                            : {rom_addr, rom_half, rom_addr[7:0]} ^ 32'ha5a5a5a5;
                if (rom_addr[22:20] != expected_region(size))
                    region_bad <= region_bad + 1;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    // line buffer capture
    always @(posedge clk) begin
        if (cap_clear) begin
            got_count  <= 0;
            done_count <= 0;
            for (int i = 0; i < 512; i++)
                got_line[i] <= '0;
        end else begin
            if (buf_wr) begin
                got_line[buf_addr] <= {1'b1, buf_data};
                got_count          <= got_count + 1;
            end
            if (done)
                done_count <= done_count + 1;
        end
    end

    task automatic run_line(input logic [2:0] sz, input logic [8:0] vr, input logic [15:0] base,
            input logic [15:0] hp, input logic [15:0] vp, input int mode, input bit twice);
        int exp_count;
        int cycles;
        if (hung)
            return;
        lat_mode  = mode;
        exp_count = expect_line(sz, vr, base, hp, vp);
        @(posedge clk);
        cap_clear <= 1'b1;
        size      <= sz;
        vrender   <= vr;
        vram_base <= base;
        hpos      <= hp;
        vpos      <= vp;
        start     <= 1'b1;
        @(posedge clk);
        cap_clear <= 1'b0;
        start     <= 1'b0;
        @(negedge clk);   // counts of the previous line are cleared by now
        cycles = 0;
        if (twice) begin
            // second start lands while the line is being written
            while (got_count == 0 && cycles < 20000) begin
                @(negedge clk);
                cycles++;
            end
            if (got_count == 0) begin
                hung = 1'b1;
                $display("timed out after %0d cycles waiting for the first write on line %0d",
                         cycles, lines);
                return;
            end
            @(posedge clk);
            vrender <= vr + 9'd37;   // would show as a different line if taken
            start   <= 1'b1;
            @(posedge clk);
            start   <= 1'b0;
        end
        cycles = 0;
        while (done_count == 0 && cycles < 20000) begin
            @(negedge clk);
            cycles++;
        end
        if (done_count == 0) begin
            hung = 1'b1;
            $display("timed out after %0d cycles waiting for done on line %0d", cycles, lines);
            return;
        end
        repeat (40) @(negedge clk);   // a stray write or second done shows up here
        compare_value("done pulses", 32'(done_count), 32'd1);
        compare_value("buf_wr count", 32'(got_count), 32'(exp_count));
        compare_value("rom reads outside the region", 32'(region_bad), 32'd0);
        for (int i = 0; i < 512; i++)
            compare_value($sformatf("buf_data[%0d]", i), 32'(got_line[i]), 32'(exp_line[i]));
        lines++;
    endtask

    initial begin
        logic [15:0] hp32 [4];
        logic [2:0]  sz;
        logic [8:0]  vr;
        logic [15:0] b, h, v;
        void'($urandom(32'hc0f7b47d));
        rst       <= 1'b1;
        start     <= 1'b0;
        cap_clear <= 1'b0;
        vrender   <= '0;
        size      <= 3'b001;
        vram_base <= '0;
        hpos      <= '0;
        vpos      <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (20) begin
            @(negedge clk);
            compare_value("vram_cs", 32'(vram_cs), 32'd0);
            compare_value("rom_cs", 32'(rom_cs), 32'd0);
            compare_value("buf_wr", 32'(buf_wr), 32'd0);
            compare_value("done", 32'(done), 32'd0);
        end
        // 8x8 with no fine scroll
        for (int i = 0; i < 4; i++)
            run_line(3'b001, 9'(i * 67), 16'($urandom), 16'($urandom) & 16'hfff8,
                     16'($urandom), 0, 1'b0);
        for (int i = 0; i < 3; i++)
            run_line(3'b010, 9'($urandom), 16'($urandom), 16'($urandom), 16'($urandom),
                     0, 1'b0);
        hp32[0] = 16'd0;
        hp32[1] = 16'd5;
        hp32[2] = 16'd31;
        hp32[3] = 16'($urandom);
        for (int i = 0; i < 4; i++)
            run_line(3'b100, 9'($urandom), 16'($urandom), hp32[i], 16'($urandom), 0, 1'b0);
        // same line under short, zero, long and mixed latencies
        for (int s = 0; s < 3; s++) begin
            sz = 3'b001 << s;
            vr = 9'($urandom);
            b  = 16'($urandom);
            h  = 16'($urandom);
            v  = 16'($urandom);
            for (int m = 0; m < 4; m++)
                run_line(sz, vr, b, h, v, m, 1'b0);
        end
        run_line(3'b010, 9'($urandom), 16'($urandom), 16'($urandom), 16'($urandom), 0, 1'b1);
        $display("lines checked %0d, errors %0d, timeout %0d", lines, errors, hung);
        if (errors == 0 && !hung)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
tilemap_pkg.sv
stage_if.sv
tile_scan.sv
tile_rom_fetch.sv
tile_pixel_out.sv
tilemap_render.sv
tb_tilemap.sv

// File: Makefile
# Verilator build and run of the tilemap line renderer testbench

VERILATOR ?= verilator
TOP       ?= tb_tilemap
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crashed or aborted run counts as a failure too
test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "TEST FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
